/* Makefile */
TOP := tb_mpr121
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --top-module mpr121_controller \
		rtl/mpr121_pkg.sv rtl/i2c_bit_engine.sv rtl/i2c_byte_engine.sv \
		rtl/mpr121_access_fsm.sv rtl/mpr121_controller.sv

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* rtl/i2c_bit_engine.sv */
`default_nettype none

module i2c_bit_engine #(
	parameter int P_PRESCALE = 125 // clk cycles per quarter scl period
) (
	input  wire logic                 i_CLK,
	input  wire logic                 i_RSTN,
	input  wire logic                 i_bit_start,
	input  wire mpr121_pkg::bit_cmd_e i_bit_cmd,
	input  wire logic                 i_tx_bit,
	output logic                      o_bit_done,
	output logic                      o_rx_bit,
	output logic                      o_scl_oe, // 1 = pull low
	output logic                      o_sda_oe,
	input  wire logic                 i_scl,
	input  wire logic                 i_sda
);

	localparam int CNT_W = (P_PRESCALE > 1) ? $clog2(P_PRESCALE) : 1;

	logic                 r_busy;
	mpr121_pkg::bit_cmd_e r_cmd;
	logic                 r_tx_bit;
	logic [1:0]           r_quarter;
	logic [CNT_W-1:0]     r_pre_cnt;

	logic                 w_quarter_end;
	logic                 w_start_now;
	mpr121_pkg::bit_cmd_e w_sel_cmd; // command for the quarter being entered
	logic [1:0]           w_sel_q;
	logic                 w_sel_tx;
	logic                 w_scl_lvl;
	logic                 w_sda_lvl;

	assign w_quarter_end = r_busy && (r_pre_cnt == CNT_W'(P_PRESCALE - 1));
	assign o_bit_done    = w_quarter_end && (r_quarter == 2'd3);
	assign w_start_now   = i_bit_start && (!r_busy || o_bit_done); // back to back ok

	assign w_sel_cmd = w_start_now ? i_bit_cmd : r_cmd;
	assign w_sel_q   = w_start_now ? 2'd0 : r_quarter + 2'd1;
	assign w_sel_tx  = w_start_now ? i_tx_bit : r_tx_bit;

	// line levels per quarter
	always_comb
	begin
		case (w_sel_cmd)
			mpr121_pkg::BIT_START:
			begin
				// scl: keep, 1, 1, 0   sda: 1, 1, 0, 0
				w_scl_lvl = (w_sel_q == 2'd0) ? i_scl : (w_sel_q != 2'd3);
				w_sda_lvl = ~w_sel_q[1];
			end
			mpr121_pkg::BIT_STOP:
			begin
				// scl: 0, 1, 1, 1   sda: 0, 0, 1, 1
				w_scl_lvl = (w_sel_q != 2'd0);
				w_sda_lvl = w_sel_q[1];
			end
			mpr121_pkg::BIT_WRITE:
			begin
				w_scl_lvl = w_sel_q[0] ^ w_sel_q[1]; // high in q1 and q2
				w_sda_lvl = w_sel_tx;
			end
			default:
			begin
				w_scl_lvl = w_sel_q[0] ^ w_sel_q[1];
				w_sda_lvl = 1'b1; // released for the slave
			end
		endcase
	end

	always_ff @(posedge i_CLK or negedge i_RSTN)
	begin
		if (!i_RSTN)
		begin
			r_busy    <= 1'b0;
			r_cmd     <= mpr121_pkg::BIT_STOP;
			r_tx_bit  <= 1'b1;
			r_quarter <= '0;
			r_pre_cnt <= '0;
			o_rx_bit  <= 1'b1;
			o_scl_oe  <= 1'b0; // bus released
			o_sda_oe  <= 1'b0;
		end
		else
		begin
			if (w_start_now)
			begin
				r_busy    <= 1'b1;
				r_cmd     <= i_bit_cmd;
				r_tx_bit  <= i_tx_bit;
				r_quarter <= '0;
				r_pre_cnt <= '0;
				o_scl_oe  <= ~w_scl_lvl;
				o_sda_oe  <= ~w_sda_lvl;
			end
			else if (o_bit_done)
				r_busy <= 1'b0; // lines hold last levels
			else if (w_quarter_end)
			begin
				r_quarter <= w_sel_q;
				r_pre_cnt <= '0;
				o_scl_oe  <= ~w_scl_lvl;
				o_sda_oe  <= ~w_sda_lvl;
			end
			else if (r_busy)
				r_pre_cnt <= r_pre_cnt + 1'b1;

			// mid scl high, end of q1
			if (w_quarter_end && (r_quarter == 2'd1))
				o_rx_bit <= i_sda;
		end
	end

endmodule

`default_nettype wire

/* rtl/i2c_byte_engine.sv */
`default_nettype none

module i2c_byte_engine (
	input  wire logic                  i_CLK,
	input  wire logic                  i_RSTN,
	input  wire logic                  i_byte_start,
	input  wire mpr121_pkg::byte_cmd_e i_byte_cmd,
	input  wire mpr121_pkg::byte_t     i_tx_byte,
	output logic                       o_byte_done,
	output mpr121_pkg::byte_t          o_rx_byte,
	output logic                       o_ack_ok,
	output logic                       o_bit_start,
	output mpr121_pkg::bit_cmd_e       o_bit_cmd,
	output logic                       o_tx_bit,
	input  wire logic                  i_bit_done,
	input  wire logic                  i_rx_bit
);

	typedef enum logic [2:0] {
		B_IDLE,
		B_START, // start slot in flight
		B_DATA,  // 8 data slots
		B_ACK,   // ninth slot
		B_STOP
	} byte_state_e;

	byte_state_e       r_state;
	logic              r_is_read;
	logic [2:0]        r_bit_cnt;
	mpr121_pkg::byte_t r_shift; // msb goes out first

	always_ff @(posedge i_CLK or negedge i_RSTN)
	begin
		if (!i_RSTN)
		begin
			r_state     <= B_IDLE;
			r_is_read   <= 1'b0;
			r_bit_cnt   <= '0;
			r_shift     <= '0;
			o_byte_done <= 1'b0;
			o_rx_byte   <= '0;
			o_ack_ok    <= 1'b0;
			o_bit_start <= 1'b0;
			o_bit_cmd   <= mpr121_pkg::BIT_STOP;
			o_tx_bit    <= 1'b1;
		end
		else
		begin
			o_byte_done <= 1'b0;
			o_bit_start <= 1'b0;
			case (r_state)
				B_IDLE:
				begin
					if (i_byte_start)
					begin
						r_shift     <= i_tx_byte;
						r_bit_cnt   <= '0;
						r_is_read   <= (i_byte_cmd == mpr121_pkg::BYTE_READ_NACK);
						o_bit_start <= 1'b1;
						o_tx_bit    <= i_tx_byte[7];
						case (i_byte_cmd)
							mpr121_pkg::BYTE_START_WRITE:
							begin
								o_bit_cmd <= mpr121_pkg::BIT_START;
								r_state   <= B_START;
							end
							mpr121_pkg::BYTE_WRITE:
							begin
								o_bit_cmd <= mpr121_pkg::BIT_WRITE;
								r_state   <= B_DATA;
							end
							mpr121_pkg::BYTE_READ_NACK:
							begin
								o_bit_cmd <= mpr121_pkg::BIT_READ; // sda released
								r_state   <= B_DATA;
							end
							default:
							begin
								o_bit_cmd <= mpr121_pkg::BIT_STOP;
								r_state   <= B_STOP;
							end
						endcase
					end
				end
				B_START:
				begin
					if (i_bit_done)
					begin
						o_bit_start <= 1'b1;
						o_bit_cmd   <= mpr121_pkg::BIT_WRITE;
						o_tx_bit    <= r_shift[7];
						r_state     <= B_DATA;
					end
				end
				B_DATA:
				begin
					if (i_bit_done)
					begin
						r_shift     <= {r_shift[6:0], i_rx_bit}; // shift in on reads
						o_bit_start <= 1'b1;
						if (r_bit_cnt == 3'd7)
						begin
							// ninth slot: read slave ack, or send our nack
							o_bit_cmd <= r_is_read ? mpr121_pkg::BIT_WRITE : mpr121_pkg::BIT_READ;
							o_tx_bit  <= 1'b1;
							r_state   <= B_ACK;
						end
						else
						begin
							o_bit_cmd <= r_is_read ? mpr121_pkg::BIT_READ : mpr121_pkg::BIT_WRITE;
							o_tx_bit  <= r_shift[6]; // next bit out
							r_bit_cnt <= r_bit_cnt + 1'b1;
						end
					end
				end
				B_ACK:
				begin
					if (i_bit_done)
					begin
						o_rx_byte   <= r_shift;
						o_ack_ok    <= r_is_read | ~i_rx_bit; // low sda = ack
						o_byte_done <= 1'b1;
						r_state     <= B_IDLE;
					end
				end
				B_STOP:
				begin
					if (i_bit_done)
					begin
						o_ack_ok    <= 1'b1;
						o_byte_done <= 1'b1;
						r_state     <= B_IDLE;
					end
				end
				default: r_state <= B_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/mpr121_access_fsm.sv */
`default_nettype none

module mpr121_access_fsm #(
	parameter int P_PRESCALE = 125,
	parameter logic [mpr121_pkg::SLAVE_ADDR_W-1:0] P_SLAVE_ADDR = mpr121_pkg::DEFAULT_SLAVE_ADDR
) (
	input  wire logic                  i_CLK,
	input  wire logic                  i_RSTN,
	input  wire mpr121_pkg::byte_t     i_reg_addr,
	input  wire mpr121_pkg::byte_t     i_wr_data,
	input  wire logic                  i_write_en,
	input  wire logic                  i_read_en,
	output mpr121_pkg::byte_t          o_rd_data,
	output logic                       o_busy,
	output logic                       o_fail,
	output logic                       o_byte_start, // one cycle strobe
	output mpr121_pkg::byte_cmd_e      o_byte_cmd,
	output mpr121_pkg::byte_t          o_tx_byte,
	input  wire logic                  i_byte_done,
	input  wire mpr121_pkg::byte_t     i_rx_byte,
	input  wire logic                  i_ack_ok
);

	// one full scl period after stop
	localparam int GUARD_CYC = 4 * P_PRESCALE;
	localparam int GUARD_W   = $clog2(GUARD_CYC);

	mpr121_pkg::access_state_e r_state;
	mpr121_pkg::byte_t         r_reg_addr; // latched request
	mpr121_pkg::byte_t         r_wr_data;
	logic                      r_is_read;
	logic [GUARD_W-1:0]        r_guard_cnt;
	logic                      w_nack; // slave missed ack on an addr or data byte

	always_comb
	begin
		w_nack = 1'b0;
		if (i_byte_done && !i_ack_ok)
		begin
			case (r_state)
				mpr121_pkg::ST_ADDR_W,
				mpr121_pkg::ST_REG_ADDR,
				mpr121_pkg::ST_WR_DATA,
				mpr121_pkg::ST_RESTART_R: w_nack = 1'b1;
				default:                  w_nack = 1'b0;
			endcase
		end
	end

	always_ff @(posedge i_CLK or negedge i_RSTN)
	begin
		if (!i_RSTN)
		begin
			r_state      <= mpr121_pkg::ST_IDLE;
			r_reg_addr   <= '0;
			r_wr_data    <= '0;
			r_is_read    <= 1'b0;
			r_guard_cnt  <= '0;
			o_rd_data    <= '0;
			o_busy       <= 1'b0;
			o_fail       <= 1'b0;
			o_byte_start <= 1'b0;
			o_byte_cmd   <= mpr121_pkg::BYTE_STOP;
			o_tx_byte    <= '0;
		end
		else
		begin
			o_byte_start <= 1'b0; // strobe
			if (w_nack)
			begin
				// abort, close the bus and flag it
				o_fail       <= 1'b1;
				o_byte_start <= 1'b1;
				o_byte_cmd   <= mpr121_pkg::BYTE_STOP;
				r_state      <= mpr121_pkg::ST_STOP;
			end
			else
			begin
				case (r_state)
					mpr121_pkg::ST_IDLE:
					begin
						if (i_write_en || i_read_en)
						begin
							r_reg_addr   <= i_reg_addr;
							r_wr_data    <= i_wr_data;
							r_is_read    <= !i_write_en; // write wins
							o_busy       <= 1'b1;
							o_byte_start <= 1'b1;
							o_byte_cmd   <= mpr121_pkg::BYTE_START_WRITE;
							o_tx_byte    <= {P_SLAVE_ADDR, 1'b0}; // addr + W
							r_state      <= mpr121_pkg::ST_ADDR_W;
						end
					end
					mpr121_pkg::ST_ADDR_W:
					begin
						if (i_byte_done)
						begin
							o_byte_start <= 1'b1;
							o_byte_cmd   <= mpr121_pkg::BYTE_WRITE;
							o_tx_byte    <= r_reg_addr;
							r_state      <= mpr121_pkg::ST_REG_ADDR;
						end
					end
					mpr121_pkg::ST_REG_ADDR:
					begin
						if (i_byte_done)
						begin
							o_byte_start <= 1'b1;
							if (r_is_read)
							begin
								o_byte_cmd <= mpr121_pkg::BYTE_START_WRITE; // repeated start
								o_tx_byte  <= {P_SLAVE_ADDR, 1'b1};        // addr + R
								r_state    <= mpr121_pkg::ST_RESTART_R;
							end
							else
							begin
								o_byte_cmd <= mpr121_pkg::BYTE_WRITE;
								o_tx_byte  <= r_wr_data;
								r_state    <= mpr121_pkg::ST_WR_DATA;
							end
						end
					end
					mpr121_pkg::ST_RESTART_R:
					begin
						if (i_byte_done)
						begin
							o_byte_start <= 1'b1;
							o_byte_cmd   <= mpr121_pkg::BYTE_READ_NACK; // single byte read
							r_state      <= mpr121_pkg::ST_RD_DATA;
						end
					end
					mpr121_pkg::ST_WR_DATA,
					mpr121_pkg::ST_RD_DATA:
					begin
						if (i_byte_done)
						begin
							if (r_state == mpr121_pkg::ST_RD_DATA)
								o_rd_data <= i_rx_byte;
							o_byte_start <= 1'b1;
							o_byte_cmd   <= mpr121_pkg::BYTE_STOP;
							r_state      <= mpr121_pkg::ST_STOP;
						end
					end
					mpr121_pkg::ST_STOP:
					begin
						if (i_byte_done)
						begin
							r_guard_cnt <= '0;
							r_state     <= mpr121_pkg::ST_GUARD;
						end
					end
					mpr121_pkg::ST_GUARD:
					begin
						// bus idle for one scl period before busy drops
						if (r_guard_cnt == GUARD_W'(GUARD_CYC - 1))
						begin
							o_busy  <= 1'b0;
							r_state <= mpr121_pkg::ST_DONE;
						end
						else
							r_guard_cnt <= r_guard_cnt + 1'b1;
					end
					mpr121_pkg::ST_DONE:
					begin
						// wait for host to drop its enable
						if (!i_write_en && !i_read_en)
						begin
							o_fail  <= 1'b0;
							r_state <= mpr121_pkg::ST_IDLE;
						end
					end
					default: r_state <= mpr121_pkg::ST_IDLE;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/mpr121_controller.sv */
`default_nettype none

module mpr121_controller #(
	parameter int P_PRESCALE = 125, // clk cycles per quarter scl period
	parameter logic [mpr121_pkg::SLAVE_ADDR_W-1:0] P_SLAVE_ADDR = mpr121_pkg::DEFAULT_SLAVE_ADDR
) (
	input  wire logic               i_CLK,
	input  wire logic               i_RSTN,
	input  wire mpr121_pkg::byte_t  i_reg_addr, // mpr121 register address
	input  wire mpr121_pkg::byte_t  i_wr_data,  // byte to write
	input  wire logic               i_write_en, // level, wins over read
	input  wire logic               i_read_en,
	output mpr121_pkg::byte_t       o_rd_data,
	output logic                    o_busy,
	output logic                    o_fail,     // missed ack
	inout  wire                     io_scl,
	inout  wire                     io_sda
);

	// sequencer <-> byte engine
	logic                  w_byte_start;
	mpr121_pkg::byte_cmd_e w_byte_cmd;
	mpr121_pkg::byte_t     w_tx_byte;
	logic                  w_byte_done;
	mpr121_pkg::byte_t     w_rx_byte;
	logic                  w_ack_ok;

	// byte engine <-> bit engine
	logic                  w_bit_start;
	mpr121_pkg::bit_cmd_e  w_bit_cmd;
	logic                  w_tx_bit;
	logic                  w_bit_done;
	logic                  w_rx_bit;

	logic w_scl_oe; // 1 pulls the line low
	logic w_sda_oe;

	// open drain, pullups are external
	assign io_scl = w_scl_oe ? 1'b0 : 1'bz;
	assign io_sda = w_sda_oe ? 1'b0 : 1'bz;

	mpr121_access_fsm #(
		.P_PRESCALE   (P_PRESCALE),
		.P_SLAVE_ADDR (P_SLAVE_ADDR)
	) i_mpr121_access_fsm (
		.i_CLK        (i_CLK),
		.i_RSTN       (i_RSTN),
		.i_reg_addr   (i_reg_addr),
		.i_wr_data    (i_wr_data),
		.i_write_en   (i_write_en),
		.i_read_en    (i_read_en),
		.o_rd_data    (o_rd_data),
		.o_busy       (o_busy),
		.o_fail       (o_fail),
		.o_byte_start (w_byte_start),
		.o_byte_cmd   (w_byte_cmd),
		.o_tx_byte    (w_tx_byte),
		.i_byte_done  (w_byte_done),
		.i_rx_byte    (w_rx_byte),
		.i_ack_ok     (w_ack_ok)
	);

	i2c_byte_engine i_i2c_byte_engine (
		.i_CLK        (i_CLK),
		.i_RSTN       (i_RSTN),
		.i_byte_start (w_byte_start),
		.i_byte_cmd   (w_byte_cmd),
		.i_tx_byte    (w_tx_byte),
		.o_byte_done  (w_byte_done),
		.o_rx_byte    (w_rx_byte),
		.o_ack_ok     (w_ack_ok),
		.o_bit_start  (w_bit_start),
		.o_bit_cmd    (w_bit_cmd),
		.o_tx_bit     (w_tx_bit),
		.i_bit_done   (w_bit_done),
		.i_rx_bit     (w_rx_bit)
	);

	i2c_bit_engine #(
		.P_PRESCALE (P_PRESCALE)
	) i_i2c_bit_engine (
		.i_CLK       (i_CLK),
		.i_RSTN      (i_RSTN),
		.i_bit_start (w_bit_start),
		.i_bit_cmd   (w_bit_cmd),
		.i_tx_bit    (w_tx_bit),
		.o_bit_done  (w_bit_done),
		.o_rx_bit    (w_rx_bit),
		.o_scl_oe    (w_scl_oe),
		.o_sda_oe    (w_sda_oe),
		.i_scl       (io_scl), // raw line levels back in
		.i_sda       (io_sda)
	);

endmodule

`default_nettype wire

/* rtl/mpr121_pkg.sv */
`default_nettype none

package mpr121_pkg;

	localparam int BYTE_W       = 8; // one bus byte
	localparam int SLAVE_ADDR_W = 7; // 7-bit i2c addressing

	typedef logic [BYTE_W-1:0] byte_t;

	// mpr121 with ADDR tied to 3Vo
	localparam logic [SLAVE_ADDR_W-1:0] DEFAULT_SLAVE_ADDR = 7'h5B;

	// single bit slot commands, START with scl low gives a repeated start
	typedef enum logic [1:0] {
		BIT_START,
		BIT_STOP,
		BIT_WRITE,
		BIT_READ
	} bit_cmd_e;

	typedef enum logic [1:0] {
		BYTE_START_WRITE, // start slot then byte
		BYTE_WRITE,
		BYTE_READ_NACK,   // read byte, master answers nack
		BYTE_STOP         // stop slot only
	} byte_cmd_e;

	// register access sequencer
	typedef enum logic [3:0] {
		ST_IDLE,
		ST_ADDR_W,
		ST_REG_ADDR,
		ST_WR_DATA,
		ST_RESTART_R,
		ST_RD_DATA,
		ST_STOP,
		ST_GUARD,
		ST_DONE
	} access_state_e;

endpackage

`default_nettype wire

/* tb.f */
rtl/mpr121_pkg.sv
rtl/i2c_bit_engine.sv
rtl/i2c_byte_engine.sv
rtl/mpr121_access_fsm.sv
rtl/mpr121_controller.sv
tb/mpr121_model.sv
tb/tb_mpr121.sv

/* tb/mpr121_model.sv */
`default_nettype none

module mpr121_model (
	input  wire logic i_scl,
	inout  wire       io_sda,
	input  wire logic i_ack_en,  // 0 = slave never answers
	output logic      o_bus_err  // sticky
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [6:0] MY_ADDR = 7'h5B;

	logic [7:0] regs [0:255];
	logic [7:0] rx_log [0:511]; // every byte clocked in from the master
	int         rx_cnt;
	int         start_cnt;

	logic       r_sda_low;
	logic       in_xfer;
	logic       skip_fall;  // scl fall that closes a START
	logic       selected;   // our address and ack switch on
	logic       rd_mode;
	logic       sending;    // slave drives the data byte
	int         bit_cnt;    // 0..7 data, 8 = ack slot
	int         byte_idx;
	logic [7:0] shift;
	logic [7:0] tx;
	logic [7:0] ptr;        // register pointer
	logic       last_scl;
	logic       last_sda;

	assign io_sda = r_sda_low ? 1'b0 : 1'bz;

	initial
	begin
		for (int k = 0; k < 256; k++)
			regs[k] = 8'(k) ^ 8'hA5; // power-up pattern
		rx_cnt    = 0;
		start_cnt = 0;
		r_sda_low = 1'b0;
		in_xfer   = 1'b0;
		skip_fall = 1'b0;
		selected  = 1'b0;
		rd_mode   = 1'b0;
		sending   = 1'b0;
		bit_cnt   = 0;
		byte_idx  = 0;
		shift     = '0;
		tx        = '0;
		ptr       = '0;
		last_scl  = 1'b1;
		last_sda  = 1'b1;
		o_bus_err = 1'b0;
	end

	always @(i_scl or io_sda)
	begin
		if (i_scl === 1'b1 && last_scl === 1'b1 && io_sda !== last_sda)
		begin
			// sda moved with scl high, start or stop
			if (bit_cnt != 0)
			begin
				$display("slave model: SDA changed inside a byte with SCL high at %0t", $time);
				o_bus_err = 1'b1;
			end
			bit_cnt   = 0;
			byte_idx  = 0;
			sending   = 1'b0;
			r_sda_low = 1'b0;
			if (io_sda === 1'b0)
			begin
				start_cnt++;
				in_xfer   = 1'b1;
				skip_fall = 1'b1;
			end
			else
				in_xfer = 1'b0; // stop
		end
		else if (in_xfer && i_scl === 1'b1 && last_scl !== 1'b1)
		begin
			if (bit_cnt < 8)
				shift = {shift[6:0], (io_sda === 1'b1)};
			else if (sending && io_sda !== 1'b1)
			begin
				$display("slave model: master acked a single read byte at %0t", $time);
				o_bus_err = 1'b1;
			end
		end
		else if (in_xfer && i_scl === 1'b0 && last_scl === 1'b1)
		begin
			if (skip_fall)
				skip_fall = 1'b0;
			else if (bit_cnt < 7)
			begin
				bit_cnt++;
				if (sending)
					r_sda_low = !tx[7 - bit_cnt]; // next bit, msb first
			end
			else if (bit_cnt == 7)
			begin
				bit_cnt = 8;
				if (sending)
					r_sda_low = 1'b0; // master answers this slot
				else
				begin
					rx_log[rx_cnt] = shift;
					rx_cnt++;
					if (byte_idx == 0)
					begin
						selected = (shift[7:1] == MY_ADDR) && i_ack_en;
						rd_mode  = shift[0];
					end
					else if (selected && byte_idx == 1)
						ptr = shift;
					else if (selected)
					begin
						regs[ptr] = shift;
						ptr++;
					end
					r_sda_low = selected; // ack
				end
			end
			else
			begin
				// end of ack slot
				bit_cnt   = 0;
				byte_idx++;
				r_sda_low = 1'b0;
				sending   = selected && rd_mode && (byte_idx == 1);
				if (sending)
				begin
					tx        = regs[ptr];
					r_sda_low = !tx[7];
				end
			end
		end
		last_scl = i_scl;
		last_sda = io_sda;
	end

endmodule

`default_nettype wire

/* tb/tb_mpr121.sv */
`default_nettype none

module tb_mpr121;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int         PRESCALE = 4;
	localparam int         CLK_NS   = 8;
	localparam int         SLOT_CYC = 4 * PRESCALE; // one bit slot
	localparam int         N_TRANS  = 70;           // upper bound on transfers run
	localparam logic [6:0] SLAVE    = 7'h5B;

	logic                      clk;
	logic                      rstn;
	mpr121_pkg::byte_t         reg_addr;
	mpr121_pkg::byte_t         wr_data;
	logic                      write_en;
	logic                      read_en;
	mpr121_pkg::byte_t         rd_data;
	logic                      busy;
	logic                      fail;
	logic                      ack_en;  // model ack switch
	logic                      bus_err;
	tri1                       w_scl;   // pull-up
	tri1                       w_sda;
	logic [31:0]               lfsr;
	logic [7:0]                shadow [0:255];
	mpr121_pkg::access_state_e fsm_state;

	assign fsm_state = i_mpr121_controller.i_mpr121_access_fsm.r_state;

	mpr121_controller #(
		.P_PRESCALE   (PRESCALE),
		.P_SLAVE_ADDR (SLAVE)
	) i_mpr121_controller (
		.i_CLK      (clk),
		.i_RSTN     (rstn),
		.i_reg_addr (reg_addr),
		.i_wr_data  (wr_data),
		.i_write_en (write_en),
		.i_read_en  (read_en),
		.o_rd_data  (rd_data),
		.o_busy     (busy),
		.o_fail     (fail),
		.io_scl     (w_scl),
		.io_sda     (w_sda)
	);

	mpr121_model i_mpr121_model (
		.i_scl     (w_scl),
		.io_sda    (w_sda),
		.i_ack_en  (ack_en),
		.o_bus_err (bus_err)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	task automatic abort_run(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic flag_mismatch(input string what, input logic [7:0] got, input logic [7:0] exp);
		$display("Mismatch at %0t ns: %s got %02h expected %02h", $time, what, got, exp);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic expect_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
		assert (got === exp)
		else flag_mismatch(what, got, exp);
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [7:0] v);
		v = '0;
		for (int k = 0; k < n; k++)
		begin
			lfsr = lfsr_step(lfsr); // one step per bit
			v    = {v[6:0], lfsr[0]};
		end
	endtask

	// called on a falling edge
	task automatic drop_enables();
		int n;
		write_en = 1'b0;
		read_en  = 1'b0;
		n = 0;
		while (fail)
		begin
			@(negedge clk);
			n++;
			if (n > 2)
				abort_run("fail flag did not clear after the enable dropped");
		end
	endtask

	task automatic do_access(input logic is_wr, input logic [7:0] addr, input logic [7:0] data,
		input logic hold);
		int         n;
		int         base;
		int         base_starts;
		int         exp_len;
		int         exp_starts;
		logic [7:0] exp_log [0:2];

		base        = i_mpr121_model.rx_cnt;
		base_starts = i_mpr121_model.start_cnt;
		exp_log[0]  = {SLAVE, 1'b0};
		exp_log[1]  = addr;
		exp_log[2]  = is_wr ? data : {SLAVE, 1'b1};
		exp_len     = ack_en ? 3 : 1; // address nack ends it early
		exp_starts  = (ack_en && !is_wr) ? 2 : 1; // repeated start on reads
		@(negedge clk);
		reg_addr = addr;
		wr_data  = data;
		write_en = is_wr;
		read_en  = !is_wr;
		n = 0;
		while (!busy)
		begin
			@(negedge clk);
			n++;
			if (n > 2)
				abort_run("busy never rose after a request");
		end
		n = 0;
		while (busy)
		begin
			@(negedge clk);
			n++;
			if (n > 45 * SLOT_CYC)
				abort_run("transfer did not finish");
		end
		expect_byte("fail flag", 8'(fail), 8'(!ack_en));
		assert (w_scl === 1'b1 && w_sda === 1'b1)
		else abort_run("bus not released after transfer");
		expect_byte("slave byte count", 8'(i_mpr121_model.rx_cnt - base), 8'(exp_len));
		expect_byte("start count", 8'(i_mpr121_model.start_cnt - base_starts), 8'(exp_starts));
		for (int k = 0; k < exp_len; k++)
			expect_byte("slave byte", i_mpr121_model.rx_log[base + k], exp_log[k]);
		if (ack_en && !is_wr)
			expect_byte("read data", rd_data, shadow[addr]);
		if (ack_en && is_wr)
			shadow[addr] = data;
		if (!hold)
			drop_enables();
	endtask

	// busy follows a request seen in idle by exactly one clock
	assert property (@(posedge clk) disable iff (!rstn)
		(fsm_state == mpr121_pkg::ST_IDLE && (write_en || read_en)) |=> busy)
	else abort_run("busy did not rise one cycle after a request in idle");

	assert property (@(posedge clk) disable iff (!rstn)
		(fsm_state == mpr121_pkg::ST_DONE && (write_en || read_en))
			|=> (!busy && fsm_state == mpr121_pkg::ST_DONE))
	else abort_run("a held enable restarted the controller");

	assert property (@(posedge clk) !bus_err)
	else abort_run("slave model flagged a bus protocol error");

	initial
	begin
		logic [7:0] a;
		logic [7:0] d;
		logic [7:0] rw;
		int         starts;

		rstn     = 1'b0;
		reg_addr = '0;
		wr_data  = '0;
		write_en = 1'b0;
		read_en  = 1'b0;
		ack_en   = 1'b1;
		lfsr     = 32'd96011;
		for (int k = 0; k < 256; k++)
			shadow[k] = 8'(k) ^ 8'hA5; // part power-up contents

		repeat (5) @(negedge clk);
		assert (!busy && !fail && rd_data === 8'h00)
		else abort_run("outputs not cleared by reset");
		assert (w_scl === 1'b1 && w_sda === 1'b1)
		else abort_run("bus not released in reset");
		rstn = 1'b1;

		// write then read back
		take_bits(8, a);
		take_bits(8, d);
		do_access(1'b1, a, d, 1'b0);
		do_access(1'b0, a, 8'h00, 1'b0);
		expect_byte("readback", rd_data, d);

		a = a ^ 8'h01; // neighbour never written
		do_access(1'b0, a, 8'h00, 1'b0);
		expect_byte("untouched register", rd_data, a ^ 8'hA5);

		// slave silent, both directions
		ack_en = 1'b0;
		do_access(1'b1, a, 8'h3C, 1'b0);
		do_access(1'b0, a, 8'h00, 1'b0);
		ack_en = 1'b1;

		// enable held past the end of the transfer
		take_bits(8, a);
		take_bits(8, d);
		do_access(1'b1, a, d, 1'b1);
		starts = i_mpr121_model.start_cnt;
		repeat (3 * SLOT_CYC)
		begin
			@(negedge clk);
			assert (!busy)
			else abort_run("busy rose while the enable was still held");
		end
		assert (i_mpr121_model.start_cnt == starts)
		else abort_run("a second START went out on a held enable");
		drop_enables();

		// small address space so reads hit earlier writes
		repeat (60)
		begin
			take_bits(1, rw);
			take_bits(4, a);
			take_bits(8, d);
			do_access(rw[0], a, d, 1'b0);
		end

		$display("Test completed successfully");
		$finish;
	end

	// worst case 40 bit slots per transfer
	initial
	begin
		#(N_TRANS * 40 * SLOT_CYC * CLK_NS + 20000);
		$display("Timeout at %0t ns: transfers did not complete in time", $time);
		$display("Test failed");
		$fatal(1);
	end

endmodule

`default_nettype wire
